// ==== core_pkg.sv ====
// shared widths and encodings of the RV32I subset; only the opcodes and funct codes this core decodes are listed
package core_pkg;

    // --------------------
    // widths
    // --------------------
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  alu_op_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // --------------------
    // ALU operations
    // --------------------
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;
    localparam alu_op_t ALU_SLT = 3'd5;

    // --------------------
    // major opcodes
    // --------------------
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;

    // funct3 for OP / OP-IMM
    localparam funct3_t F3_ADD = 3'b000;
    localparam funct3_t F3_SLT = 3'b010;
    localparam funct3_t F3_XOR = 3'b100;
    localparam funct3_t F3_OR  = 3'b110;
    localparam funct3_t F3_AND = 3'b111;

    // funct3 for BRANCH
    localparam funct3_t F3_BEQ = 3'b000;
    localparam funct3_t F3_BNE = 3'b001;

    // funct7 for OP
    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_SUB  = 7'b0100000;

    // --------------------
    // program counter
    // --------------------
    localparam word_t RESET_PC   = 32'h0000_0000;
    localparam word_t INST_BYTES = 32'd4;

endpackage

// ==== fetch.sv ====
// fetch stage for a fixed one-cycle instruction memory; PC holds while i_exec is low, redirect wins over exec
`timescale 1ns/1ps

module fetch (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_exec,
    input  logic             i_redirect,
    input  core_pkg::word_t  i_target,
    input  core_pkg::word_t  i_imem_data,
    output core_pkg::word_t  o_imem_addr,
    output logic             o_f_valid,
    output core_pkg::word_t  o_f_pc,
    output core_pkg::word_t  o_f_inst
);
    import core_pkg::*;

    word_t pc;
    // address of the word now coming back from memory
    word_t pc_q;
    logic  valid_q;

    // --------------------
    // program counter
    // --------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc      <= RESET_PC;
            valid_q <= 1'b0;
        end else begin
            if (i_redirect) begin
                pc <= i_target;
            end else if (i_exec) begin
                pc <= pc + INST_BYTES;
            end
            // address sent this cycle is wanted only if exec is on and no redirect kills it
            valid_q <= i_exec && !i_redirect;
        end
    end

    always_ff @(posedge i_clk) begin
        pc_q <= pc;
    end

    assign o_imem_addr = pc;
    assign o_f_valid   = valid_q;
    assign o_f_pc      = pc_q;
    assign o_f_inst    = i_imem_data;

    // redirect targets come from execute, so alignment holds across the loop
    a_addr_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        pc[1:0] == 2'b00)
        else $error("fetch address not word aligned");

endmodule

// ==== decode.sv ====
// decode stage; unsupported opcodes and funct codes drop the valid bit and never reach retire
`timescale 1ns/1ps

module decode (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_flush,
    input  logic                 i_f_valid,
    input  core_pkg::word_t      i_f_pc,
    input  core_pkg::word_t      i_f_inst,
    input  core_pkg::word_t      i_rs1_val,
    input  core_pkg::word_t      i_rs2_val,
    output core_pkg::reg_addr_t  o_rs1,
    output core_pkg::reg_addr_t  o_rs2,
    output logic                 o_d_valid,
    output core_pkg::word_t      o_d_pc,
    output core_pkg::alu_op_t    o_d_alu_op,
    output core_pkg::word_t      o_d_imm,
    output logic                 o_d_use_imm,
    output logic                 o_d_is_branch,
    output logic                 o_d_branch_ne,
    output logic                 o_d_is_jal,
    output logic                 o_d_is_lui,
    output core_pkg::reg_addr_t  o_d_rd,
    output core_pkg::reg_addr_t  o_d_rs1_idx,
    output core_pkg::reg_addr_t  o_d_rs2_idx,
    output core_pkg::word_t      o_d_rs1_val,
    output core_pkg::word_t      o_d_rs2_val
);
    import core_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    word_t   imm_i;
    word_t   imm_u;
    word_t   imm_b;
    word_t   imm_j;
    alu_op_t f3_op;
    logic    f3_known;
    alu_op_t alu_op;
    word_t   imm;
    logic    known;
    logic    use_imm;
    logic    is_branch;
    logic    is_jal;
    logic    is_lui;

    // --------------------
    // fields and immediates
    // --------------------
    assign opcode = i_f_inst[6:0];
    assign funct3 = i_f_inst[14:12];
    assign funct7 = i_f_inst[31:25];
    assign o_rs1  = i_f_inst[19:15];
    assign o_rs2  = i_f_inst[24:20];

    assign imm_i = {{20{i_f_inst[31]}}, i_f_inst[31:20]};
    assign imm_u = {i_f_inst[31:12], 12'b0};
    assign imm_b = {{19{i_f_inst[31]}}, i_f_inst[31], i_f_inst[7], i_f_inst[30:25],
                    i_f_inst[11:8], 1'b0};
    assign imm_j = {{11{i_f_inst[31]}}, i_f_inst[31], i_f_inst[19:12], i_f_inst[20],
                    i_f_inst[30:21], 1'b0};

    // funct3 map shared by OP and OP-IMM
    always_comb begin
        f3_known = 1'b1;
        case (funct3)
            F3_ADD:  f3_op = ALU_ADD;
            F3_SLT:  f3_op = ALU_SLT;
            F3_XOR:  f3_op = ALU_XOR;
            F3_OR:   f3_op = ALU_OR;
            F3_AND:  f3_op = ALU_AND;
            default: begin
                f3_op    = ALU_ADD;
                f3_known = 1'b0;
            end
        endcase
    end

    always_comb begin
        known     = 1'b0;
        alu_op    = ALU_ADD;
        imm       = imm_i;
        use_imm   = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        is_lui    = 1'b0;
        case (opcode)
            OPC_OP: begin
                // only SUB may carry the alternate funct7
                known  = f3_known && (funct7 == F7_BASE ||
                                      (funct7 == F7_SUB && funct3 == F3_ADD));
                alu_op = (funct7 == F7_SUB) ? ALU_SUB : f3_op;
            end
            OPC_OP_IMM: begin
                known   = f3_known;
                alu_op  = f3_op;
                use_imm = 1'b1;
            end
            OPC_LUI: begin
                known  = 1'b1;
                imm    = imm_u;
                is_lui = 1'b1;
            end
            OPC_BRANCH: begin
                known     = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
                imm       = imm_b;
                is_branch = 1'b1;
            end
            OPC_JAL: begin
                known  = 1'b1;
                imm    = imm_j;
                is_jal = 1'b1;
            end
            default: known = 1'b0;
        endcase
    end

    // --------------------
    // pipeline register
    // --------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_d_valid <= 1'b0;
        end else begin
            o_d_valid <= i_f_valid && known && !i_flush;
        end
    end

    always_ff @(posedge i_clk) begin
        o_d_pc        <= i_f_pc;
        o_d_alu_op    <= alu_op;
        o_d_imm       <= imm;
        o_d_use_imm   <= use_imm;
        o_d_is_branch <= is_branch;
        o_d_branch_ne <= (funct3 == F3_BNE);
        o_d_is_jal    <= is_jal;
        o_d_is_lui    <= is_lui;
        o_d_rd        <= i_f_inst[11:7];
        o_d_rs1_idx   <= o_rs1;
        o_d_rs2_idx   <= o_rs2;
        o_d_rs1_val   <= i_rs1_val;
        o_d_rs2_val   <= i_rs2_val;
    end

endmodule

// ==== regfile.sv ====
// 31 writable registers cleared at reset, x0 reads zero; reads and debug port see a same-cycle write
`timescale 1ns/1ps

module regfile (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_we,
    input  core_pkg::reg_addr_t  i_waddr,
    input  core_pkg::word_t      i_wdata,
    input  core_pkg::reg_addr_t  i_raddr1,
    input  core_pkg::reg_addr_t  i_raddr2,
    input  core_pkg::reg_addr_t  i_dbg_addr,
    output core_pkg::word_t      o_rdata1,
    output core_pkg::word_t      o_rdata2,
    output core_pkg::word_t      o_dbg_data
);
    import core_pkg::*;

    word_t regs [1:31];

    // zero for x0, else write-through, else array
    function automatic word_t read_reg(input reg_addr_t addr);
        word_t val;
        if (addr == '0) begin
            val = '0;
        end else if (i_we && addr == i_waddr) begin
            val = i_wdata;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_waddr != '0) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    always_comb begin
        o_rdata1   = read_reg(i_raddr1);
        o_rdata2   = read_reg(i_raddr2);
        o_dbg_data = read_reg(i_dbg_addr);
    end

    // execute must already have dropped rd 0
    a_no_x0_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_we |-> i_waddr != '0)
        else $error("register file write to x0");

endmodule

// ==== execute.sv ====
// execute stage and retire register; forwards only from its own retire register, older results come via the register file
`timescale 1ns/1ps

module execute (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_d_valid,
    input  core_pkg::word_t      i_d_pc,
    input  core_pkg::alu_op_t    i_d_alu_op,
    input  core_pkg::word_t      i_d_imm,
    input  logic                 i_d_use_imm,
    input  logic                 i_d_is_branch,
    input  logic                 i_d_branch_ne,
    input  logic                 i_d_is_jal,
    input  logic                 i_d_is_lui,
    input  core_pkg::reg_addr_t  i_d_rd,
    input  core_pkg::reg_addr_t  i_d_rs1_idx,
    input  core_pkg::reg_addr_t  i_d_rs2_idx,
    input  core_pkg::word_t      i_d_rs1_val,
    input  core_pkg::word_t      i_d_rs2_val,
    output logic                 o_redirect,
    output core_pkg::word_t      o_target,
    output logic                 o_wb_valid,
    output core_pkg::reg_addr_t  o_wb_rd,
    output core_pkg::word_t      o_wb_data
);
    import core_pkg::*;

    word_t op_a;
    word_t rs2_fwd;
    word_t op_b;
    word_t alu_out;
    word_t result;
    logic  lt;
    logic  taken;
    logic  writes_rd;

    // --------------------
    // operand forwarding
    // --------------------
    // retire valid is never set for x0, so no extra rd check here
    assign op_a    = (o_wb_valid && o_wb_rd == i_d_rs1_idx) ? o_wb_data : i_d_rs1_val;
    assign rs2_fwd = (o_wb_valid && o_wb_rd == i_d_rs2_idx) ? o_wb_data : i_d_rs2_val;
    assign op_b    = i_d_use_imm ? i_d_imm : rs2_fwd;

    // --------------------
    // ALU
    // --------------------
    assign lt = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (i_d_alu_op)
            ALU_ADD: alu_out = op_a + op_b;
            ALU_SUB: alu_out = op_a - op_b;
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_XOR: alu_out = op_a ^ op_b;
            ALU_SLT: alu_out = {31'b0, lt};
            default: alu_out = op_a + op_b;
        endcase
    end

    always_comb begin
        if (i_d_is_jal) begin
            // link value
            result = i_d_pc + INST_BYTES;
        end else if (i_d_is_lui) begin
            result = i_d_imm;
        end else begin
            result = alu_out;
        end
    end

    // --------------------
    // branch and jump
    // --------------------
    assign taken      = i_d_is_branch && ((op_a == rs2_fwd) != i_d_branch_ne);
    assign o_redirect = i_d_valid && (i_d_is_jal || taken);
    assign o_target   = i_d_pc + i_d_imm;

    // branches have no rd
    assign writes_rd = i_d_valid && !i_d_is_branch && (i_d_rd != '0);

    // --------------------
    // retire register
    // --------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_valid <= 1'b0;
        end else begin
            o_wb_valid <= writes_rd;
        end
    end

    always_ff @(posedge i_clk) begin
        o_wb_rd   <= i_d_rd;
        o_wb_data <= result;
    end

    // pc from fetch plus immediate from decode must stay word aligned
    a_target_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_redirect |-> o_target[1:0] == 2'b00)
        else $error("redirect target not word aligned");

    // decode flush must empty the slot behind a redirect
    a_redirect_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_redirect |=> !o_redirect)
        else $error("redirect held for more than one cycle");

endmodule

// ==== core.sv ====
// RV32I subset core, no loads or stores; instruction memory must answer exactly one cycle after the address
`timescale 1ns/1ps

module core (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_exec,
    input  core_pkg::word_t      i_imem_data,
    input  core_pkg::reg_addr_t  i_dbg_addr,
    output core_pkg::word_t      o_imem_addr,
    output core_pkg::word_t      o_pc,
    output logic                 o_wb_valid,
    output core_pkg::reg_addr_t  o_wb_rd,
    output core_pkg::word_t      o_wb_data,
    output core_pkg::word_t      o_dbg_data
);
    import core_pkg::*;

    // fetch -> decode
    logic      f_valid;
    word_t     f_pc;
    word_t     f_inst;

    // register file reads
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_val;
    word_t     rs2_val;

    // decode -> execute
    logic      d_valid;
    word_t     d_pc;
    alu_op_t   d_alu_op;
    word_t     d_imm;
    logic      d_use_imm;
    logic      d_is_branch;
    logic      d_branch_ne;
    logic      d_is_jal;
    logic      d_is_lui;
    reg_addr_t d_rd;
    reg_addr_t d_rs1_idx;
    reg_addr_t d_rs2_idx;
    word_t     d_rs1_val;
    word_t     d_rs2_val;

    // control flow back to the front end
    logic      redirect;
    word_t     target;

    // PC shown for debug is the address going out
    assign o_pc = o_imem_addr;

    fetch u_fetch (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_exec      (i_exec),
        .i_redirect  (redirect),
        .i_target    (target),
        .i_imem_data (i_imem_data),
        .o_imem_addr (o_imem_addr),
        .o_f_valid   (f_valid),
        .o_f_pc      (f_pc),
        .o_f_inst    (f_inst)
    );

    decode u_decode (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_flush       (redirect),
        .i_f_valid     (f_valid),
        .i_f_pc        (f_pc),
        .i_f_inst      (f_inst),
        .i_rs1_val     (rs1_val),
        .i_rs2_val     (rs2_val),
        .o_rs1         (rs1),
        .o_rs2         (rs2),
        .o_d_valid     (d_valid),
        .o_d_pc        (d_pc),
        .o_d_alu_op    (d_alu_op),
        .o_d_imm       (d_imm),
        .o_d_use_imm   (d_use_imm),
        .o_d_is_branch (d_is_branch),
        .o_d_branch_ne (d_branch_ne),
        .o_d_is_jal    (d_is_jal),
        .o_d_is_lui    (d_is_lui),
        .o_d_rd        (d_rd),
        .o_d_rs1_idx   (d_rs1_idx),
        .o_d_rs2_idx   (d_rs2_idx),
        .o_d_rs1_val   (d_rs1_val),
        .o_d_rs2_val   (d_rs2_val)
    );

    regfile u_regfile (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_we       (o_wb_valid),
        .i_waddr    (o_wb_rd),
        .i_wdata    (o_wb_data),
        .i_raddr1   (rs1),
        .i_raddr2   (rs2),
        .i_dbg_addr (i_dbg_addr),
        .o_rdata1   (rs1_val),
        .o_rdata2   (rs2_val),
        .o_dbg_data (o_dbg_data)
    );

    execute u_execute (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_d_valid     (d_valid),
        .i_d_pc        (d_pc),
        .i_d_alu_op    (d_alu_op),
        .i_d_imm       (d_imm),
        .i_d_use_imm   (d_use_imm),
        .i_d_is_branch (d_is_branch),
        .i_d_branch_ne (d_branch_ne),
        .i_d_is_jal    (d_is_jal),
        .i_d_is_lui    (d_is_lui),
        .i_d_rd        (d_rd),
        .i_d_rs1_idx   (d_rs1_idx),
        .i_d_rs2_idx   (d_rs2_idx),
        .i_d_rs1_val   (d_rs1_val),
        .i_d_rs2_val   (d_rs2_val),
        .o_redirect    (redirect),
        .o_target      (target),
        .o_wb_valid    (o_wb_valid),
        .o_wb_rd       (o_wb_rd),
        .o_wb_data     (o_wb_data)
    );

endmodule

// ==== tb_clk_gen.sv ====
// free-running 8 ns clock; reset is held low for the first 10 cycles and released on a falling edge
`timescale 1ns/1ps

module tb_clk_gen (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #4 o_clk = ~o_clk;
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (10) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule

// ==== tb_core.sv ====
// one program per run, built at time zero; it must end in a jump to itself so the core idles at the end
`timescale 1ns/1ps

module tb_core;
    import core_pkg::*;

    localparam int RAND_BASE   = 20;
    localparam int RAND_LEN    = 48;
    localparam int PROG_LEN    = RAND_BASE + RAND_LEN + 1;
    localparam int MODEL_STEPS = 1000;
    localparam int RESET_WAIT  = 50;
    localparam int RUN_WAIT    = 2000;

    logic      clk;
    logic      rst_n;
    logic      i_exec;
    word_t     i_imem_data;
    reg_addr_t i_dbg_addr;
    word_t     o_imem_addr;
    word_t     o_pc;
    logic      o_wb_valid;
    reg_addr_t o_wb_rd;
    word_t     o_wb_data;
    word_t     o_dbg_data;

    word_t     rom [0:PROG_LEN-1];
    word_t     addr_prev = RESET_PC;
    reg_addr_t exp_rd [$];
    word_t     exp_data [$];
    word_t     model_regs [0:31];
    int        ret_count = 0;
    int        check_count = 0;
    int        err_count = 0;
    int        timeout_count = 0;

    tb_clk_gen u_clk_gen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    core u_dut (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_exec      (i_exec),
        .i_imem_data (i_imem_data),
        .i_dbg_addr  (i_dbg_addr),
        .o_imem_addr (o_imem_addr),
        .o_pc        (o_pc),
        .o_wb_valid  (o_wb_valid),
        .o_wb_rd     (o_wb_rd),
        .o_wb_data   (o_wb_data),
        .o_dbg_data  (o_dbg_data)
    );

    // --------------------
    // encoders and ROM
    // --------------------
    function automatic word_t enc_r(input funct7_t f7, input reg_addr_t rs2, input reg_addr_t rs1,
                                    input funct3_t f3, input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input funct3_t f3, input reg_addr_t rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic word_t enc_u(input logic [19:0] imm, input reg_addr_t rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic word_t enc_b(input logic [12:0] off, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input funct3_t f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t enc_j(input logic [20:0] off, input reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // outside the program the fill has opcode 0, which the ISA subset treats as a no-op
    function automatic word_t rom_word(input word_t addr);
        int idx;
        idx = int'(addr[31:2]);
        if (idx < PROG_LEN) begin
            return rom[idx];
        end
        return {addr[31:7] ^ addr[24:0], 7'b0};
    endfunction

    function automatic funct3_t pick_f3(input int k);
        case (k)
            0:       return F3_ADD;
            1:       return F3_SLT;
            2:       return F3_XOR;
            3:       return F3_OR;
            default: return F3_AND;
        endcase
    endfunction

    function automatic void build_program();
        int        k;
        int        kind;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        // dependent chain
        rom[0]  = enc_i(12'd5, 5'd0, F3_ADD, 5'd1);
        rom[1]  = enc_r(F7_BASE, 5'd1, 5'd1, F3_ADD, 5'd2);
        rom[2]  = enc_r(F7_SUB, 5'd1, 5'd2, F3_ADD, 5'd3);
        rom[3]  = enc_i(12'hFF9, 5'd3, F3_ADD, 5'd4);
        rom[4]  = enc_r(F7_BASE, 5'd2, 5'd4, F3_ADD, 5'd5);
        // taken and not-taken branches
        rom[5]  = enc_b(13'd12, 5'd1, 5'd1, F3_BEQ);
        rom[6]  = enc_i(12'd99, 5'd0, F3_ADD, 5'd6);
        rom[7]  = enc_i(12'd77, 5'd0, F3_ADD, 5'd7);
        rom[8]  = enc_b(13'd8, 5'd1, 5'd1, F3_BNE);
        rom[9]  = enc_i(12'd11, 5'd0, F3_ADD, 5'd8);
        rom[10] = enc_b(13'd8, 5'd2, 5'd1, F3_BNE);
        rom[11] = enc_i(12'd55, 5'd0, F3_ADD, 5'd9);
        rom[12] = enc_b(13'd8, 5'd2, 5'd1, F3_BEQ);
        // LUI and jumps
        rom[13] = enc_u(20'hABCDE, 5'd10);
        rom[14] = enc_j(21'd12, 5'd11);
        rom[15] = enc_i(12'd1, 5'd0, F3_ADD, 5'd12);
        rom[16] = enc_i(12'd1, 5'd0, F3_ADD, 5'd13);
        rom[17] = enc_j(21'd8, 5'd0);
        rom[18] = enc_i(12'd3, 5'd0, F3_ADD, 5'd14);
        // unsupported opcode naming x15 never retires
        rom[19] = 32'h0000_07FF;
        for (k = 0; k < RAND_LEN; k++) begin
            kind = $urandom_range(0, 11);
            rd   = reg_addr_t'($urandom_range(0, 11));
            rs1  = reg_addr_t'($urandom_range(0, 11));
            rs2  = reg_addr_t'($urandom_range(0, 11));
            if (kind < 5) begin
                rom[RAND_BASE + k] = enc_r(F7_BASE, rs2, rs1, pick_f3(kind), rd);
            end else if (kind == 5) begin
                rom[RAND_BASE + k] = enc_r(F7_SUB, rs2, rs1, F3_ADD, rd);
            end else if (kind < 11) begin
                rom[RAND_BASE + k] = enc_i(12'($urandom), rs1, pick_f3(kind - 6), rd);
            end else begin
                rom[RAND_BASE + k] = enc_u(20'($urandom), rd);
            end
        end
        rom[PROG_LEN - 1] = enc_j(21'd0, 5'd0);
    endfunction

    // --------------------
    // reference model
    // --------------------
    function automatic logic alu_ref(input funct3_t f3, input logic sub, input word_t a,
                                     input word_t b, output word_t y);
        y = '0;
        if (sub) begin
            y = a - b;
            return 1'b1;
        end
        case (f3)
            F3_ADD:  y = a + b;
            F3_SLT:  y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_XOR:  y = a ^ b;
            F3_OR:   y = a | b;
            F3_AND:  y = a & b;
            default: return 1'b0;
        endcase
        return 1'b1;
    endfunction

    function automatic void run_model();
        word_t     pc;
        word_t     next;
        word_t     inst;
        word_t     val;
        word_t     a;
        word_t     b;
        opcode_t   opc;
        funct3_t   f3;
        funct7_t   f7;
        reg_addr_t rd;
        logic      wr;
        logic      done;
        int        steps;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        pc    = RESET_PC;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < MODEL_STEPS) begin
            inst = rom_word(pc);
            opc  = inst[6:0];
            rd   = inst[11:7];
            f3   = inst[14:12];
            f7   = inst[31:25];
            a    = model_regs[inst[19:15]];
            b    = model_regs[inst[24:20]];
            next = pc + 32'd4;
            wr   = 1'b0;
            val  = '0;
            case (opc)
                OPC_OP: begin
                    if (f7 == F7_BASE || (f7 == F7_SUB && f3 == F3_ADD)) begin
                        wr = alu_ref(f3, f7 == F7_SUB, a, b, val);
                    end
                end
                OPC_OP_IMM: wr = alu_ref(f3, 1'b0, a, {{20{inst[31]}}, inst[31:20]}, val);
                OPC_LUI: begin
                    wr  = 1'b1;
                    val = {inst[31:12], 12'b0};
                end
                OPC_BRANCH: begin
                    if ((f3 == F3_BEQ && a == b) || (f3 == F3_BNE && a != b)) begin
                        next = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                     inst[11:8], 1'b0};
                    end
                end
                OPC_JAL: begin
                    wr   = 1'b1;
                    val  = pc + 32'd4;
                    next = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                 inst[30:21], 1'b0};
                    done = (next == pc);
                end
                default: ;
            endcase
            if (wr && rd != '0) begin
                model_regs[rd] = val;
                exp_rd.push_back(rd);
                exp_data.push_back(val);
            end
            pc = next;
            steps++;
        end
    endfunction

    // --------------------
    // checking
    // --------------------
    task automatic check_value(input string what, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp) begin
            $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (!rst_n && cycles < RESET_WAIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!rst_n) begin
            $display("TIMEOUT: reset was never released after %0d cycles", RESET_WAIT);
            timeout_count++;
        end
    endtask

    task automatic wait_retired(input int n, input string what);
        int cycles;
        cycles = 0;
        while (ret_count < n && cycles < RUN_WAIT) begin
            @(negedge clk);
            cycles++;
        end
        if (ret_count < n) begin
            $display("TIMEOUT: %s never came, only %0d of %0d retirements seen",
                     what, ret_count, n);
            timeout_count++;
        end
    endtask

    task automatic dump_registers();
        for (int r = 0; r < 32; r++) begin
            @(negedge clk);
            i_dbg_addr = reg_addr_t'(r);
            @(negedge clk);
            check_value($sformatf("debug read of x%0d", r), o_dbg_data, model_regs[r]);
        end
    endtask

    task automatic finish_run();
        $display("checks: %0d, mismatches: %0d, timeouts: %0d",
                 check_count, err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    // instruction memory answers one cycle after the address
    always @(negedge clk) begin
        i_imem_data <= rom_word(addr_prev);
        addr_prev   <= o_imem_addr;
    end

    // compare every retirement with the next model entry
    always @(negedge clk) begin
        if (rst_n && o_wb_valid) begin
            if (ret_count < exp_rd.size()) begin
                check_value("retired rd", word_t'(o_wb_rd), word_t'(exp_rd[ret_count]));
                check_value("retired data", o_wb_data, exp_data[ret_count]);
            end else begin
                $display("ERROR %0t: extra retirement of x%0d beyond the model's list",
                         $time, o_wb_rd);
                err_count++;
            end
            ret_count++;
        end
    end

    // --------------------
    // main sequence
    // --------------------
    initial begin
        int drop_at;
        int gap;
        i_exec      = 1'b0;
        i_imem_data = '0;
        i_dbg_addr  = '0;
        void'($urandom(32'h8518));
        build_program();
        run_model();
        wait_reset_release();
        if (timeout_count == 0) begin
            // idle with exec low
            repeat (6) begin
                @(negedge clk);
                check_value("wb_valid while idle", word_t'(o_wb_valid), '0);
                check_value("imem address while idle", o_imem_addr, RESET_PC);
                check_value("pc while idle", o_pc, RESET_PC);
            end
            i_exec = 1'b1;
        end
        if (timeout_count == 0) begin
            drop_at = $urandom_range(10, exp_rd.size() - 10);
            wait_retired(drop_at, "retirement before the exec pause");
        end
        if (timeout_count == 0) begin
            gap    = $urandom_range(3, 12);
            i_exec = 1'b0;
            repeat (gap) @(negedge clk);
            i_exec = 1'b1;
            wait_retired(exp_rd.size(), "final expected retirement");
        end
        if (timeout_count == 0) begin
            // the closing self jump must not retire anything more
            repeat (30) @(negedge clk);
            check_value("retirement count", word_t'(ret_count), word_t'(exp_rd.size()));
            dump_registers();
        end
        finish_run();
    end

endmodule

// ==== list.f ====
core_pkg.sv
fetch.sv
decode.sv
regfile.sv
execute.sv
core.sv
tb_clk_gen.sv
tb_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f list.f \
    --top-module tb_core \
    -o tb_core_sim

# the log decides pass or fail, not the exit status of the simulator
./obj_dir/tb_core_sim > sim.log 2>&1 || echo "simulator exited with an error status"
cat sim.log

grep -q "^Result: PASSED$" sim.log
echo "simulation passed"
